/* hw/ads_defines.svh */
`ifndef ADS_DEFINES_SVH
`define ADS_DEFINES_SVH

// SCLK half period in system clocks
`define ADS_CLKS_PER_HALF_BIT 4
`define ADS_CS_HOLD_CYCLES 5 // CSN low after last byte
`define ADS_SETTLE_EDGES 6 // DRDY edges after START
`define ADS_DATA_SETTLE_CYCLES 32 // DRDY fall to first frame byte
`define ADS_FRAME_BYTES 9 // Status plus two channels

// Result slots held by the host
`define ADS_HOST_CREDITS 2
`define ADS_FIFO_DEPTH 2

// Register opcode prefixes, address in low five bits
`define ADS_OP_RREG 3'b001
`define ADS_OP_WREG 3'b010
`define ADS_OP_RDATAC 8'h10
`define ADS_OP_SDATAC 8'h11

`endif

/* hw/ads_pkg.sv */
package ads_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [71:0] frame_t; // First received byte in [71:64]

	// Host request codes
	typedef enum logic [2:0] {
		REQ_SYSCMD = 3'd1,
		REQ_WREG = 3'd2,
		REQ_RREG = 3'd3,
		REQ_RDATAC = 3'd4,
		REQ_SDATAC = 3'd5
	} req_e;

	typedef enum logic [2:0] {
		ST_IDLE, ST_ACK, ST_SEND, ST_XFER, ST_HOLD, ST_SETTLE, ST_WAIT_DRDY, ST_DSETTLE
	} ctrl_state_e;

endpackage

/* hw/spi_byte_engine.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module spi_byte_engine #(
	parameter int CLKS_PER_HALF_BIT = `ADS_CLKS_PER_HALF_BIT
) (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_tx_valid, // Only sent while holding the credit
	input ads_pkg::byte_t i_tx_byte,
	input logic i_spi_miso,
	output logic o_tx_credit,
	output logic o_rx_valid,
	output ads_pkg::byte_t o_rx_byte,
	output logic o_spi_clk, // Mode 0, idles low
	output logic o_spi_mosi
);
	localparam int DW = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;

	logic r_busy;
	logic [DW-1:0] r_div; // Half-bit divider
	logic [3:0] r_edge; // 16 SCLK edges per byte
	logic r_done;
	logic w_tick;
	ads_pkg::byte_t r_tx_sr;
	ads_pkg::byte_t r_rx_sr;

	assign w_tick = r_busy && (r_div == DW'(CLKS_PER_HALF_BIT - 1));
	assign o_tx_credit = r_done; // Byte out and byte in finish together
	assign o_rx_valid = r_done;
	assign o_rx_byte = r_rx_sr;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_busy <= 1'b0;
			r_div <= '0;
			r_edge <= '0;
			r_done <= 1'b0;
			o_spi_clk <= 1'b0;
			o_spi_mosi <= 1'b0;
		end else begin
			r_done <= 1'b0;
			if (!r_busy) begin
				if (i_tx_valid) begin
					r_busy <= 1'b1;
					r_div <= '0;
					r_edge <= '0;
					o_spi_mosi <= i_tx_byte[7]; // MSB set up a half bit ahead
				end
			end else begin
				r_div <= w_tick ? '0 : r_div + 1'b1;
				if (w_tick) begin
					o_spi_clk <= ~o_spi_clk;
					r_edge <= r_edge + 4'd1;
					if (o_spi_clk && r_edge != 4'd15)
						o_spi_mosi <= r_tx_sr[6]; // Next bit on falling edge
					if (r_edge == 4'd15) begin // Last falling edge
						r_busy <= 1'b0;
						r_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_CLK) begin
		if (!r_busy && i_tx_valid)
			r_tx_sr <= i_tx_byte;
		else if (w_tick && o_spi_clk)
			r_tx_sr <= {r_tx_sr[6:0], 1'b0};
		if (w_tick && !o_spi_clk)
			r_rx_sr <= {r_rx_sr[6:0], i_spi_miso}; // Sample on rising edge
	end

endmodule

/* hw/drdy_monitor.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module drdy_monitor (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_drdy_n, // Asynchronous, active low
	input logic i_arm, // Restart settle count
	output logic o_fall,
	output logic o_settled
);
	localparam int CW = $clog2(`ADS_SETTLE_EDGES + 1);

	logic r_meta;
	logic r_sync;
	logic r_last; // Previous synchronized level
	logic [CW-1:0] r_edges;

	assign o_settled = (r_edges == CW'(`ADS_SETTLE_EDGES));

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_meta <= 1'b1; // DRDY idles high
			r_sync <= 1'b1;
			r_last <= 1'b1;
			o_fall <= 1'b0;
			r_edges <= '0;
		end else begin
			r_meta <= i_drdy_n;
			r_sync <= r_meta;
			r_last <= r_sync;
			o_fall <= r_last & ~r_sync; // Third cycle after the pin edge
			if (i_arm)
				r_edges <= '0;
			else if ((r_last ^ r_sync) && !o_settled)
				r_edges <= r_edges + 1'b1; // Either polarity counts
		end
	end

endmodule

/* hw/result_fifo.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module result_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = `ADS_FIFO_DEPTH
) (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_push,
	input T i_data,
	input logic i_credit, // Host freed one slot
	output logic o_full,
	output logic o_valid,
	output T o_data
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam int KW = $clog2(`ADS_HOST_CREDITS + 1);

	T mem [DEPTH];
	logic [AW-1:0] r_wr;
	logic [AW-1:0] r_rd;
	logic [CW-1:0] r_count;
	logic [KW-1:0] r_credits; // Host slots still free
	logic w_push;
	logic w_pop;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign o_full = (r_count == CW'(DEPTH));
	assign w_push = i_push && !o_full; // Writer checks full first
	assign w_pop = (r_count != '0) && (r_credits != '0);

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_wr <= '0;
			r_rd <= '0;
			r_count <= '0;
			r_credits <= KW'(`ADS_HOST_CREDITS);
			o_valid <= 1'b0;
		end else begin
			o_valid <= w_pop; // One item per cycle at most
			if (w_push)
				r_wr <= next_ptr(r_wr);
			if (w_pop)
				r_rd <= next_ptr(r_rd);
			r_count <= r_count + CW'(w_push) - CW'(w_pop);
			r_credits <= r_credits + KW'(i_credit) - KW'(w_pop);
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_push)
			mem[r_wr] <= i_data;
		if (w_pop)
			o_data <= mem[r_rd];
	end

endmodule

/* hw/ads_ctrl.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module ads_ctrl (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_req_valid,
	input ads_pkg::req_e i_req,
	input ads_pkg::byte_t i_cmd,
	input ads_pkg::byte_t i_addr,
	input ads_pkg::byte_t i_wdata,
	input logic i_tx_credit,
	input logic i_rx_valid,
	input ads_pkg::byte_t i_rx_byte,
	input logic i_fall,
	input logic i_settled,
	input logic i_frm_full,
	output logic o_tx_valid,
	output ads_pkg::byte_t o_tx_byte,
	output logic o_arm,
	output logic o_reg_push,
	output ads_pkg::byte_t o_reg_data,
	output logic o_frm_push,
	output ads_pkg::frame_t o_frm_data,
	output logic o_req_credit,
	output logic o_busy,
	output logic o_spi_csn,
	output logic o_start
);
	localparam int CW = $clog2(`ADS_DATA_SETTLE_CYCLES + 1);

	ads_pkg::ctrl_state_e r_state;
	ads_pkg::req_e r_req; // Latched request
	ads_pkg::byte_t r_cmd;
	logic [4:0] r_addr;
	ads_pkg::byte_t r_wdata;
	ads_pkg::frame_t r_frm; // Bytes of the frame so far
	logic r_tx_cred; // Engine's single byte credit
	logic [3:0] r_idx; // Byte index in transaction
	logic [3:0] r_nbytes;
	logic [CW-1:0] r_cnt; // CS hold and data settle
	logic r_frame; // Transaction is a data frame
	logic r_stream;
	logic r_stop_pend; // SDATAC seen while streaming
	logic w_last;
	logic w_hold_done;

	function automatic logic [3:0] req_len(input ads_pkg::req_e req);
		case (req)
			ads_pkg::REQ_WREG, ads_pkg::REQ_RREG: return 4'd3; // Opcode, count, data
			default: return 4'd1;
		endcase
	endfunction

	assign o_busy = (r_state != ads_pkg::ST_IDLE);
	assign o_tx_valid = (r_state == ads_pkg::ST_SEND) && r_tx_cred;
	assign w_last = (r_state == ads_pkg::ST_XFER) && i_rx_valid && (r_idx == r_nbytes - 4'd1);
	assign w_hold_done = (r_state == ads_pkg::ST_HOLD) && (r_cnt == CW'(`ADS_CS_HOLD_CYCLES - 1));
	assign o_req_credit = (w_hold_done && !r_frame) || (r_state == ads_pkg::ST_ACK);
	assign o_arm = w_hold_done && !r_frame && (r_req == ads_pkg::REQ_RDATAC);
	assign o_reg_push = w_last && !r_frame && (r_req == ads_pkg::REQ_RREG);
	assign o_reg_data = i_rx_byte; // Dummy slot carries the register
	assign o_frm_push = w_last && r_frame;
	assign o_frm_data = {r_frm[63:0], i_rx_byte};

	// Byte for current index
	always_comb begin
		o_tx_byte = 8'h00; // Count byte and frame dummies
		if (!r_frame) begin
			case (r_req)
				ads_pkg::REQ_WREG: begin
					if (r_idx == 4'd0)
						o_tx_byte = {`ADS_OP_WREG, r_addr};
					else if (r_idx == 4'd2)
						o_tx_byte = r_wdata;
				end
				ads_pkg::REQ_RREG: begin
					if (r_idx == 4'd0)
						o_tx_byte = {`ADS_OP_RREG, r_addr};
				end
				ads_pkg::REQ_RDATAC: o_tx_byte = `ADS_OP_RDATAC;
				ads_pkg::REQ_SDATAC: o_tx_byte = `ADS_OP_SDATAC;
				default: o_tx_byte = r_cmd; // System command as given
			endcase
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_req_valid) begin
			r_req <= i_req;
			r_cmd <= i_cmd;
			r_addr <= i_addr[4:0];
			r_wdata <= i_wdata;
		end
		if (r_state == ads_pkg::ST_XFER && i_rx_valid)
			r_frm <= {r_frm[63:0], i_rx_byte};
	end

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state <= ads_pkg::ST_IDLE;
			r_tx_cred <= 1'b1;
			r_idx <= '0;
			r_nbytes <= '0;
			r_cnt <= '0;
			r_frame <= 1'b0;
			r_stream <= 1'b0;
			r_stop_pend <= 1'b0;
			o_spi_csn <= 1'b1;
			o_start <= 1'b0;
		end else begin
			if (o_tx_valid)
				r_tx_cred <= 1'b0;
			else if (i_tx_credit)
				r_tx_cred <= 1'b1;
			if (i_req_valid && r_stream)
				r_stop_pend <= 1'b1; // Only SDATAC allowed here
			case (r_state)
				ads_pkg::ST_IDLE: begin
					if (i_req_valid) begin
						if (i_req == ads_pkg::REQ_SDATAC) begin
							r_state <= ads_pkg::ST_ACK; // Nothing to stop
						end else begin
							o_spi_csn <= 1'b0;
							r_idx <= '0;
							r_nbytes <= req_len(i_req);
							r_state <= ads_pkg::ST_SEND;
						end
					end
				end
				ads_pkg::ST_ACK: r_state <= ads_pkg::ST_IDLE;
				ads_pkg::ST_SEND: begin
					if (r_tx_cred)
						r_state <= ads_pkg::ST_XFER;
				end
				ads_pkg::ST_XFER: begin
					if (i_rx_valid) begin
						r_idx <= r_idx + 4'd1;
						r_cnt <= '0;
						r_state <= w_last ? ads_pkg::ST_HOLD : ads_pkg::ST_SEND;
					end
				end
				ads_pkg::ST_HOLD: begin
					r_cnt <= r_cnt + 1'b1;
					if (w_hold_done) begin
						o_spi_csn <= 1'b1;
						if (r_frame) begin
							r_frame <= 1'b0;
							r_state <= ads_pkg::ST_WAIT_DRDY;
						end else if (r_req == ads_pkg::REQ_RDATAC) begin
							o_start <= 1'b1; // Conversions begin
							r_stream <= 1'b1;
							r_state <= ads_pkg::ST_SETTLE;
						end else begin
							if (r_req == ads_pkg::REQ_SDATAC) begin
								o_start <= 1'b0;
								r_stream <= 1'b0;
							end
							r_state <= ads_pkg::ST_IDLE;
						end
					end
				end
				ads_pkg::ST_SETTLE, ads_pkg::ST_WAIT_DRDY: begin
					if (r_stop_pend) begin
						r_stop_pend <= 1'b0;
						o_spi_csn <= 1'b0;
						r_idx <= '0;
						r_nbytes <= 4'd1; // SDATAC opcode
						r_state <= ads_pkg::ST_SEND;
					end else if (r_state == ads_pkg::ST_SETTLE) begin
						if (i_settled)
							r_state <= ads_pkg::ST_WAIT_DRDY;
					end else if (i_fall && !i_frm_full) begin // Full queue skips this DRDY
						r_cnt <= '0;
						r_state <= ads_pkg::ST_DSETTLE;
					end
				end
				ads_pkg::ST_DSETTLE: begin
					r_cnt <= r_cnt + 1'b1;
					if (r_cnt == CW'(`ADS_DATA_SETTLE_CYCLES - 1)) begin
						o_spi_csn <= 1'b0;
						r_frame <= 1'b1;
						r_idx <= '0;
						r_nbytes <= 4'(`ADS_FRAME_BYTES);
						r_state <= ads_pkg::ST_SEND;
					end
				end
				default: r_state <= ads_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

/* hw/ads_top.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module ads_top (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_req_valid,
	input ads_pkg::req_e i_req,
	input ads_pkg::byte_t i_cmd,
	input ads_pkg::byte_t i_addr,
	input ads_pkg::byte_t i_wdata,
	output logic o_req_credit,
	output logic o_busy,
	output logic o_reg_valid,
	output ads_pkg::byte_t o_reg_data,
	input logic i_reg_credit,
	output logic o_frm_valid,
	output ads_pkg::frame_t o_frm_data,
	input logic i_frm_credit,
	output logic o_spi_clk,
	output logic o_spi_mosi,
	input logic i_spi_miso,
	input logic i_drdy_n,
	output logic o_spi_csn,
	output logic o_start
);
	logic w_tx_valid;
	ads_pkg::byte_t w_tx_byte;
	logic w_tx_credit;
	logic w_rx_valid;
	ads_pkg::byte_t w_rx_byte;
	logic w_fall;
	logic w_settled;
	logic w_arm;
	logic w_reg_push;
	ads_pkg::byte_t w_reg_data;
	logic w_frm_push;
	ads_pkg::frame_t w_frm_data;
	logic w_frm_full; // Frame queue back-pressure

	ads_ctrl u_ctrl (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_req_valid(i_req_valid), .i_req(i_req),
		.i_cmd(i_cmd), .i_addr(i_addr), .i_wdata(i_wdata),
		.i_tx_credit(w_tx_credit), .i_rx_valid(w_rx_valid), .i_rx_byte(w_rx_byte),
		.i_fall(w_fall), .i_settled(w_settled), .i_frm_full(w_frm_full),
		.o_tx_valid(w_tx_valid), .o_tx_byte(w_tx_byte), .o_arm(w_arm),
		.o_reg_push(w_reg_push), .o_reg_data(w_reg_data),
		.o_frm_push(w_frm_push), .o_frm_data(w_frm_data),
		.o_req_credit(o_req_credit), .o_busy(o_busy),
		.o_spi_csn(o_spi_csn), .o_start(o_start)
	);

	spi_byte_engine #(.CLKS_PER_HALF_BIT(`ADS_CLKS_PER_HALF_BIT)) u_engine (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_tx_valid(w_tx_valid), .i_tx_byte(w_tx_byte), .i_spi_miso(i_spi_miso),
		.o_tx_credit(w_tx_credit), .o_rx_valid(w_rx_valid), .o_rx_byte(w_rx_byte),
		.o_spi_clk(o_spi_clk), .o_spi_mosi(o_spi_mosi)
	);

	drdy_monitor u_drdy (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN), .i_drdy_n(i_drdy_n), .i_arm(w_arm),
		.o_fall(w_fall), .o_settled(w_settled)
	);

	// Register bytes wait here for a host credit
	result_fifo #(.T(ads_pkg::byte_t), .DEPTH(`ADS_FIFO_DEPTH)) u_reg_fifo (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_push(w_reg_push), .i_data(w_reg_data), .i_credit(i_reg_credit),
		.o_full(), .o_valid(o_reg_valid), .o_data(o_reg_data)
	);

	result_fifo #(.T(ads_pkg::frame_t), .DEPTH(`ADS_FIFO_DEPTH)) u_frm_fifo (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_push(w_frm_push), .i_data(w_frm_data), .i_credit(i_frm_credit),
		.o_full(w_frm_full), .o_valid(o_frm_valid), .o_data(o_frm_data)
	);

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rstn
);
	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk; // 10 ns period
	end

	initial begin
		o_rstn = 1'b0;
		repeat (4) @(posedge o_clk);
		o_rstn <= 1'b1; // Released after 4 cycles
	end

endmodule

/* bench/ads_slave_model.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module ads_slave_model (
	input logic i_clk,
	input logic i_csn,
	input logic i_sclk,
	input logic i_mosi,
	input logic i_start,
	output logic o_miso,
	output logic o_drdy_n
);
	logic [7:0] regs [32] = '{default: 8'h00}; // Register file
	logic [7:0] cmd_log [$]; // System command bytes seen
	logic [71:0] frames [$]; // Frames shifted out, in order
	logic [71:0] r_pend; // Frame ready since last DRDY
	logic [7:0] in_sr;
	logic [7:0] out_sr;
	logic [7:0] op; // First byte of transaction
	bit in_cs = 1'b0;
	bit r_stream = 1'b0; // RDATAC mode
	int bitcnt;
	int byteidx;
	int drdy_cnt;

	assign o_miso = out_sr[7];

	// SPI slave, mode 0
	always @(i_csn or i_sclk) begin
		if (i_csn) begin
			in_cs = 1'b0;
		end else if (!in_cs) begin // CSN just fell
			in_cs = 1'b1;
			bitcnt = 0;
			byteidx = 0;
			out_sr = r_stream ? r_pend[71:64] : 8'h00;
		end else if (i_sclk) begin
			in_sr = {in_sr[6:0], i_mosi}; // Sample on rising edge
			bitcnt++;
		end else if (bitcnt == 8) begin // Byte done on last falling edge
			bitcnt = 0;
			if (byteidx == 0)
				op = in_sr;
			if (r_stream) begin
				if (byteidx == 0 && in_sr == `ADS_OP_SDATAC)
					r_stream = 1'b0;
				else if (byteidx == 8 && op != `ADS_OP_SDATAC)
					frames.push_back(r_pend); // Whole frame read
			end else if (byteidx == 0) begin
				if (in_sr == `ADS_OP_RDATAC)
					r_stream = 1'b1;
				else if (in_sr[7:5] != `ADS_OP_RREG && in_sr[7:5] != `ADS_OP_WREG)
					cmd_log.push_back(in_sr);
			end else if (byteidx == 2 && op[7:5] == `ADS_OP_WREG) begin
				regs[op[4:0]] = in_sr;
			end
			byteidx++;
			if (r_stream && byteidx < 9)
				out_sr = r_pend[71 - 8 * byteidx -: 8];
			else if (!r_stream && op[7:5] == `ADS_OP_RREG && byteidx == 2)
				out_sr = regs[op[4:0]]; // Read data in dummy slot
			else
				out_sr = 8'h00;
		end else begin
			out_sr = out_sr << 1; // Next bit on falling edge
		end
	end

	// DRDY every 800 cycles while START is high
	always @(posedge i_clk) begin
		if (!i_start) begin
			drdy_cnt <= 0;
			o_drdy_n <= 1'b1;
		end else begin
			drdy_cnt <= (drdy_cnt == 799) ? 0 : drdy_cnt + 1;
			if (drdy_cnt == 799) begin
				o_drdy_n <= 1'b0;
				r_pend <= {8'($urandom), $urandom, $urandom}; // New conversion
			end else if (drdy_cnt == 19) begin
				o_drdy_n <= 1'b1;
			end
		end
	end

endmodule

/* bench/ads_asserts.sv */
`timescale 1ns/1ps

module ads_asserts (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_req_valid,
	input logic i_tx_valid,
	input logic i_rx_valid,
	input logic i_spi_csn,
	input logic i_start,
	input logic i_req_credit,
	input ads_pkg::ctrl_state_e i_state,
	input ads_pkg::req_e i_req
);
	logic r_open; // Request taken and not yet answered

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_open <= 1'b0;
		else if (i_req_valid)
			r_open <= 1'b1;
		else if (i_req_credit)
			r_open <= 1'b0;
	end

	// SCLK runs from tx_valid through the whole transfer up to rx_valid
	a_byte_in_cs: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(i_tx_valid || i_rx_valid || i_state == ads_pkg::ST_XFER) |-> !i_spi_csn)
		else $error("SPI byte outside chip select");

	a_stop_low: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(i_req_credit && i_req == ads_pkg::REQ_SDATAC) |=> !i_start)
		else $error("START still high after SDATAC");

	a_credit_busy: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_req_credit |-> r_open)
		else $error("Request credit returned while idle");

endmodule

bind ads_ctrl ads_asserts u_asserts (
	.i_CLK(i_CLK), .i_RSTN(i_RSTN), .i_req_valid(i_req_valid),
	.i_tx_valid(o_tx_valid), .i_rx_valid(i_rx_valid),
	.i_spi_csn(o_spi_csn), .i_start(o_start), .i_req_credit(o_req_credit),
	.i_state(r_state), .i_req(r_req)
);

/* bench/tb_top.sv */
`timescale 1ns/1ps
`include "ads_defines.svh"

module tb_top;
	localparam int TIMEOUT_CYCLES = 40 * 2000 + 12 * 1000;

	logic clk, rstn, req_valid, reg_credit, frm_credit;
	ads_pkg::req_e req;
	ads_pkg::byte_t cmd, addr_b, wdata;
	logic req_credit, busy, reg_valid, frm_valid;
	ads_pkg::byte_t reg_data;
	ads_pkg::frame_t frm_data, exp_frm;
	logic sclk, mosi, miso, drdy_n, csn, start;
	int issued, returned; // Request credits spent and returned
	int reg_recv, reg_back, frm_recv, frm_back, frm_seen;
	bit hold_frm = 1'b0; // Withhold frame credits
	ads_pkg::byte_t reg_got [$];
	ads_pkg::byte_t shadow [32] = '{default: 8'h00}; // Expected register file

	tb_clk_gen clk_gen_i (.o_clk(clk), .o_rstn(rstn));

	ads_top ads_top_i (
		.i_CLK(clk), .i_RSTN(rstn), .i_req_valid(req_valid), .i_req(req),
		.i_cmd(cmd), .i_addr(addr_b), .i_wdata(wdata),
		.o_req_credit(req_credit), .o_busy(busy),
		.o_reg_valid(reg_valid), .o_reg_data(reg_data), .i_reg_credit(reg_credit),
		.o_frm_valid(frm_valid), .o_frm_data(frm_data), .i_frm_credit(frm_credit),
		.o_spi_clk(sclk), .o_spi_mosi(mosi), .i_spi_miso(miso),
		.i_drdy_n(drdy_n), .o_spi_csn(csn), .o_start(start)
	);

	ads_slave_model slave_i (
		.i_clk(clk), .i_csn(csn), .i_sclk(sclk), .i_mosi(mosi), .i_start(start),
		.o_miso(miso), .o_drdy_n(drdy_n)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopped");
	endtask

	task automatic check(input string name, input logic [71:0] exp, input logic [71:0] act);
		if (exp !== act)
			fail_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	// One request and the wait for its credit
	task automatic send_req(input ads_pkg::req_e kind, input ads_pkg::byte_t c,
			input ads_pkg::byte_t a, input ads_pkg::byte_t d);
		while (returned < issued)
			@(posedge clk);
		@(posedge clk);
		req_valid <= 1'b1;
		req <= kind;
		cmd <= c;
		addr_b <= a;
		wdata <= d;
		issued++;
		@(posedge clk);
		req_valid <= 1'b0;
		while (returned < issued)
			@(posedge clk);
		repeat (3) @(posedge clk); // Outputs settled past the credit
	endtask

	// Result monitor sampled at the clock edge
	always @(posedge clk) begin
		if (rstn) begin
			if (req_credit) begin
				returned++;
				if (returned > issued)
					fail_run("Request credit returned with no request outstanding");
			end
			if (reg_valid) begin
				reg_got.push_back(reg_data);
				reg_recv++;
			end
			if (frm_valid) begin
				if (slave_i.frames.size() == 0)
					fail_run("Frame delivered that the device never shifted out");
				exp_frm = slave_i.frames.pop_front();
				check("frame_data", exp_frm, frm_data);
				frm_seen++;
				frm_recv++;
			end
		end
	end

	// Host credit returns after 0 to 20 cycles
	initial begin
		reg_credit = 1'b0;
		forever begin
			@(posedge clk);
			if (reg_recv > reg_back) begin
				repeat ($urandom_range(0, 20)) @(posedge clk);
				reg_credit <= 1'b1;
				reg_back++;
				@(posedge clk);
				reg_credit <= 1'b0;
			end
		end
	end

	initial begin
		frm_credit = 1'b0;
		forever begin
			@(posedge clk);
			if (frm_recv > frm_back && !hold_frm) begin
				repeat ($urandom_range(0, 20)) @(posedge clk);
				frm_credit <= 1'b1;
				frm_back++;
				@(posedge clk);
				frm_credit <= 1'b0;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		fail_run("Timeout: the test did not finish in the allowed time");
	end

	initial begin
		logic [4:0] a;
		ads_pkg::byte_t d;
		int n;
		int base;
		void'($urandom(32'h470ce9c1));
		req_valid = 1'b0;
		req = ads_pkg::REQ_SYSCMD;
		cmd = 8'h00;
		addr_b = 8'h00;
		wdata = 8'h00;
		wait (rstn);
		repeat (2) @(posedge clk);
		check("reset_csn", 72'(1), 72'(csn));
		check("reset_start", 72'(0), 72'(start));
		check("reset_busy", 72'(0), 72'(busy));
		check("reset_req_credit", 72'(0), 72'(req_credit));
		check("reset_reg_valid", 72'(0), 72'(reg_valid));
		check("reset_frm_valid", 72'(0), 72'(frm_valid));

		// Register round trip
		repeat (8) begin
			a = 5'($urandom_range(0, 31));
			d = 8'($urandom);
			send_req(ads_pkg::REQ_WREG, 8'h00, {3'b000, a}, d);
			shadow[a] = d;
			send_req(ads_pkg::REQ_RREG, 8'h00, {3'b000, a}, 8'h00);
			while (reg_got.size() == 0)
				@(posedge clk);
			check("rreg_data", 72'(d), 72'(reg_got.pop_front()));
			foreach (shadow[i])
				check("reg_file", 72'(shadow[i]), 72'(slave_i.regs[i]));
		end

		// System commands clear of register and stream opcodes
		repeat (6) begin
			d = 8'($urandom_range(0, 15));
			n = slave_i.cmd_log.size();
			send_req(ads_pkg::REQ_SYSCMD, d, 8'h00, 8'h00);
			check("syscmd_count", 72'(n + 1), 72'(slave_i.cmd_log.size()));
			check("syscmd_byte", 72'(d), 72'(slave_i.cmd_log[n]));
		end

		n = slave_i.cmd_log.size();
		send_req(ads_pkg::REQ_SDATAC, 8'h00, 8'h00, 8'h00); // Nothing streaming
		check("idle_stop_start", 72'(0), 72'(start));
		check("idle_stop_spi", 72'(n), 72'(slave_i.cmd_log.size()));

		// Continuous read
		send_req(ads_pkg::REQ_RDATAC, 8'h00, 8'h00, 8'h00);
		check("rdatac_start", 72'(1), 72'(start));
		while (frm_seen < 3)
			@(posedge clk);

		// Back-pressure once all credits are home
		while (frm_recv > frm_back)
			@(posedge clk);
		hold_frm = 1'b1;
		base = frm_seen;
		repeat (3500) @(posedge clk);
		check("held_frames", 72'(`ADS_HOST_CREDITS), 72'(frm_seen - base));
		hold_frm = 1'b0;
		base = frm_seen;
		while (frm_seen < base + 4)
			@(posedge clk);

		// Stop
		send_req(ads_pkg::REQ_SDATAC, 8'h00, 8'h00, 8'h00);
		check("stop_start", 72'(0), 72'(start));
		check("stop_csn", 72'(1), 72'(csn));
		check("stop_busy", 72'(0), 72'(busy));
		while (slave_i.frames.size() != 0)
			@(posedge clk);
		base = frm_seen;
		repeat (1000) @(posedge clk);
		check("frames_after_stop", 72'(base), 72'(frm_seen));
		check("unread_frames", 72'(0), 72'(slave_i.frames.size()));

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* list.f */
+incdir+hw
hw/ads_pkg.sv
hw/spi_byte_engine.sv
hw/drdy_monitor.sv
hw/result_fifo.sv
hw/ads_ctrl.sv
hw/ads_top.sv
bench/tb_clk_gen.sv
bench/ads_slave_model.sv
bench/ads_asserts.sv
bench/tb_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = list.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
